// File: verilog/fft_defines.svh
`ifndef FFT_DEFINES_SVH
`define FFT_DEFINES_SVH

// parallel lanes per input vector
`define FFT_LANES 4

// delay line length in valid vectors
// one block is 2 * FFT_DEPTH valid vectors
`define FFT_DEPTH 8

// input sample width, signed
`define FFT_IN_W 9

// butterfly output width, one growth bit over the input
`define FFT_OUT_W 10

`endif

// File: verilog/fft_pkg.sv
`include "fft_defines.svh"

package fft_pkg;

    // complex input sample
    typedef struct packed {
        logic signed [`FFT_IN_W-1:0] re;
        logic signed [`FFT_IN_W-1:0] im;
    } cplx_in_t;

    // complex butterfly output sample
    typedef struct packed {
        logic signed [`FFT_OUT_W-1:0] re;
        logic signed [`FFT_OUT_W-1:0] im;
    } cplx_out_t;

    // one sample per lane
    typedef cplx_in_t  [`FFT_LANES-1:0] lane_in_t;
    typedef cplx_out_t [`FFT_LANES-1:0] lane_out_t;

    // execute stage result handed to the result stage
    typedef struct packed {
        lane_out_t sum;    // delayed + new
        lane_out_t diff;   // delayed - new
        logic      rotate; // apply -j to diff
        logic      valid;  // pair holds a compute result
    } bfly_pair_t;

endpackage

// File: verilog/bfly_ctrl.sv
`include "fft_defines.svh"

module bfly_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic valid,
    output logic compute,
    output logic rotate
);

    localparam int BLOCK      = 2 * `FFT_DEPTH;
    localparam int IDX_W      = $clog2(BLOCK);
    localparam int TWID_START = `FFT_DEPTH + `FFT_DEPTH / 2;

    logic [IDX_W-1:0] idx;   // position of the next valid vector in its block
    logic             last;  // final vector of a block
    logic             upper; // compute half
    logic             twid;  // last quarter, -j twiddle

    assign last  = (idx == IDX_W'(BLOCK - 1));
    assign upper = (idx >= IDX_W'(`FFT_DEPTH));
    assign twid  = (idx >= IDX_W'(TWID_START));

    // index only moves on valid cycles so gaps do not shift the pairing
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idx <= '0;
        end else if (valid) begin
            if (last) begin
                idx <= '0; // wrap into the next fill half
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    assign compute = valid && upper;
    assign rotate  = twid;

endmodule

// File: verilog/bfly_addsub.sv
`include "fft_defines.svh"

module bfly_addsub (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic                compute,
    input  logic                rotate,
    input  fft_pkg::lane_in_t   din,
    output fft_pkg::bfly_pair_t pair
);

    import fft_pkg::*;

    lane_in_t  dly [`FFT_DEPTH]; // dly[0] newest
    lane_in_t  oldest;
    lane_out_t sum_d;
    lane_out_t diff_d;
    lane_out_t sum_q;
    lane_out_t diff_q;
    logic      rot_q;
    logic      vld_q;

    function automatic logic signed [`FFT_OUT_W-1:0] ext(input logic signed [`FFT_IN_W-1:0] x);
        return `FFT_OUT_W'(x); // sign extension
    endfunction

    // the vector pushed FFT_DEPTH valid cycles ago
    assign oldest = dly[`FFT_DEPTH-1];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dly <= '{default: '0};
        end else if (valid) begin
            dly[0] <= din; // always takes din, fill or compute
            for (int i = 1; i < `FFT_DEPTH; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    // lane-wise butterfly
    always_comb begin
        for (int l = 0; l < `FFT_LANES; l++) begin
            sum_d[l].re  = ext(oldest[l].re) + ext(din[l].re);
            sum_d[l].im  = ext(oldest[l].im) + ext(din[l].im);
            diff_d[l].re = ext(oldest[l].re) - ext(din[l].re);
            diff_d[l].im = ext(oldest[l].im) - ext(din[l].im);
        end
    end

    always_ff @(posedge clk) begin
        if (compute) begin
            sum_q  <= sum_d;
            diff_q <= diff_d;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            vld_q <= 1'b0;
            rot_q <= 1'b0;
        end else begin
            vld_q <= compute;
            rot_q <= rotate;
        end
    end

    assign pair = '{sum: sum_q, diff: diff_q, rotate: rot_q, valid: vld_q};

endmodule

// File: verilog/bfly_rotate.sv
`include "fft_defines.svh"

module bfly_rotate (
    input  logic                clk,
    input  logic                rst,
    input  fft_pkg::bfly_pair_t pair,
    output fft_pkg::lane_out_t  bfly_p,
    output fft_pkg::lane_out_t  bfly_n,
    output logic                out_valid
);

    import fft_pkg::*;

    lane_out_t n_d;

    // multiply by -j: (a + jb) * -j = b - ja
    // a diff of two 9-bit values stays above -512, so negation is safe
    always_comb begin
        for (int l = 0; l < `FFT_LANES; l++) begin
            if (pair.rotate) begin
                n_d[l].re = pair.diff[l].im;
                n_d[l].im = -pair.diff[l].re;
            end else begin
                n_d[l] = pair.diff[l];
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bfly_p    <= '0;
            bfly_n    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= pair.valid; // one pulse per result
            if (pair.valid) begin
                bfly_p <= pair.sum;
                bfly_n <= n_d;
            end
        end
    end

endmodule

// File: verilog/fft_stage0.sv
module fft_stage0 (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid,
    input  fft_pkg::lane_in_t  din,
    output fft_pkg::lane_out_t bfly_p,
    output fft_pkg::lane_out_t bfly_n,
    output logic               out_valid
);

    import fft_pkg::*;

    logic       compute;
    logic       rotate;
    bfly_pair_t pair;

    // decode
    bfly_ctrl i_ctrl (
        .clk     (clk),
        .rst     (rst),
        .valid   (valid),
        .compute (compute),
        .rotate  (rotate)
    );

    // execute, one cycle
    bfly_addsub i_addsub (
        .clk     (clk),
        .rst     (rst),
        .valid   (valid),
        .compute (compute),
        .rotate  (rotate),
        .din     (din),
        .pair    (pair)
    );

    // result, one more cycle
    bfly_rotate i_rotate (
        .clk       (clk),
        .rst       (rst),
        .pair      (pair),
        .bfly_p    (bfly_p),
        .bfly_n    (bfly_n),
        .out_valid (out_valid)
    );

endmodule

// File: verification/fft_stage0_checker.sv
module fft_stage0_checker (
    input logic                clk,
    input logic                rst,
    input logic                valid,
    input logic                compute,
    input fft_pkg::bfly_pair_t pair,
    input logic                out_valid
);

    // every result traces back to a valid input two edges earlier
    out_after_valid: assert property (
        @(posedge clk) disable iff (!rst)
        out_valid |-> $past(valid, 2)
    ) else $error("out_valid without a valid input two cycles earlier");

    // strobe held low while reset is applied
    quiet_in_reset: assert property (
        @(posedge clk)
        !rst |-> !out_valid
    ) else $error("out_valid high during reset");

    // execute stage only reports a pair for a compute-half input
    pair_after_compute: assert property (
        @(posedge clk) disable iff (!rst)
        pair.valid |-> $past(compute)
    ) else $error("pair.valid without compute one cycle earlier");

endmodule

// File: verification/tb_fft_stage0.sv
`include "fft_defines.svh"

module tb_fft_stage0;

    import fft_pkg::*;

    localparam int BLOCK      = 2 * `FFT_DEPTH;
    localparam int TWID_START = `FFT_DEPTH + `FFT_DEPTH / 2;
    localparam int S_MAX      = (1 << (`FFT_IN_W - 1)) - 1;
    localparam int S_MIN      = -S_MAX - 1;
    // about 10 blocks of 16 vectors plus gaps and flush stay below 400 cycles
    localparam int TIMEOUT_CYCLES = 1000;

    typedef struct {
        lane_out_t p;
        lane_out_t n;
        int        cyc; // cycle count when out_valid should be seen
    } expect_t;

    logic      clk;
    logic      rst;
    logic      valid;
    lane_in_t  din;
    lane_out_t bfly_p;
    lane_out_t bfly_n;
    logic      out_valid;

    int        seed      = 75;
    int        cycle_cnt = 0;
    int        out_cnt   = 0;
    string     cur_test  = "setup";
    int        mdl_idx   = 0;          // reference block index
    lane_in_t  mdl_dly [`FFT_DEPTH];   // reference delay line with [0] newest
    expect_t   exp_q [$];

    fft_stage0 i_dut (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .din       (din),
        .bfly_p    (bfly_p),
        .bfly_n    (bfly_n),
        .out_valid (out_valid)
    );

    bind fft_stage0 fft_stage0_checker i_checker (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .compute   (compute),
        .pair      (pair),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic compare_lane_out(input string what, input lane_out_t exp,
                                    input lane_out_t act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %h actual %h", cur_test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: %s expected %b actual %b", cur_test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_int(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s: %s expected %0d actual %0d", cur_test, what, exp, act);
            abort_run();
        end
    endtask

    // predicts the result of one valid input and advances the model
    task automatic model_push(input lane_in_t d);
        lane_in_t old;
        expect_t  e;
        int       ore;
        int       oim;
        int       dre;
        int       dim;
        old = mdl_dly[`FFT_DEPTH-1];
        if (mdl_idx >= `FFT_DEPTH) begin
            for (int l = 0; l < `FFT_LANES; l++) begin
                ore = $signed(old[l].re);
                oim = $signed(old[l].im);
                dre = ore - $signed(d[l].re);
                dim = oim - $signed(d[l].im);
                e.p[l].re = `FFT_OUT_W'(ore + $signed(d[l].re));
                e.p[l].im = `FFT_OUT_W'(oim + $signed(d[l].im));
                if (mdl_idx >= TWID_START) begin
                    e.n[l].re = `FFT_OUT_W'(dim);  // times -j
                    e.n[l].im = `FFT_OUT_W'(-dre);
                end else begin
                    e.n[l].re = `FFT_OUT_W'(dre);
                    e.n[l].im = `FFT_OUT_W'(dim);
                end
            end
            e.cyc = cycle_cnt + 2;
            exp_q.push_back(e);
        end
        for (int i = `FFT_DEPTH - 1; i > 0; i--) begin
            mdl_dly[i] = mdl_dly[i-1];
        end
        mdl_dly[0] = d;
        mdl_idx = (mdl_idx + 1) % BLOCK;
    endtask

    always @(negedge clk) begin
        expect_t e;
        if (rst === 1'b1 && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("%s: unexpected output, no result was pending", cur_test);
                abort_run();
            end else begin
                e = exp_q.pop_front();
                compare_int("output cycle", e.cyc, cycle_cnt);
                compare_lane_out("bfly_p", e.p, bfly_p);
                compare_lane_out("bfly_n", e.n, bfly_n);
                out_cnt++;
            end
        end
    end

    task automatic drive_vec(input logic v, input lane_in_t d);
        @(posedge clk);
        #1;
        valid = v;
        din   = d;
        if (v) begin
            model_push(d);
        end
    endtask

    function automatic lane_in_t rand_vec();
        lane_in_t d;
        for (int l = 0; l < `FFT_LANES; l++) begin
            d[l].re = `FFT_IN_W'($random(seed));
            d[l].im = `FFT_IN_W'($random(seed));
        end
        return d;
    endfunction

    function automatic lane_in_t ramp_vec(input int v);
        lane_in_t d;
        for (int l = 0; l < `FFT_LANES; l++) begin
            d[l].re = `FFT_IN_W'(v * 4 + l);
            d[l].im = `FFT_IN_W'(-(v * 3) - 2 * l);
        end
        return d;
    endfunction

    // full-scale lanes where flip swaps the extremes for the same k
    function automatic lane_in_t extreme_vec(input int k, input logic flip);
        lane_in_t d;
        logic     hi;
        for (int l = 0; l < `FFT_LANES; l++) begin
            hi = ((l + k) % 2 == 1) ^ flip;
            d[l].re = `FFT_IN_W'(hi ? S_MAX : S_MIN);
            d[l].im = `FFT_IN_W'(hi ? S_MIN : S_MAX);
        end
        return d;
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
        out_cnt  = 0;
        $display("running %s", name);
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            compare_bit("out_valid", 1'b0, out_valid);
        end
    endtask

    task automatic finish_test(input int n_exp);
        drive_vec(1'b0, '0);
        while (out_cnt < n_exp) begin
            @(negedge clk);
        end
        check_idle(3);
    endtask

    task automatic test_reset_state();
        start_test("reset_state");
        compare_lane_out("bfly_p", '0, bfly_p);
        compare_lane_out("bfly_n", '0, bfly_n);
        check_idle(10);
    endtask

    // early outputs trip the monitor as the fill half predicts nothing
    task automatic test_single_block();
        start_test("single_block");
        for (int v = 0; v < BLOCK; v++) begin
            drive_vec(1'b1, ramp_vec(v));
        end
        finish_test(`FFT_DEPTH);
    endtask

    task automatic test_twiddle_half();
        start_test("twiddle_half");
        for (int k = 0; k < `FFT_DEPTH; k++) begin
            drive_vec(1'b1, extreme_vec(k, 1'b0));
        end
        for (int k = 0; k < `FFT_DEPTH; k++) begin
            drive_vec(1'b1, extreme_vec(k, 1'b1)); // diffs reach +-511
        end
        finish_test(`FFT_DEPTH);
    endtask

    // same block with and without gaps against identical predictions
    task automatic test_valid_gaps();
        lane_in_t blk [BLOCK];
        start_test("valid_gaps_dense");
        for (int v = 0; v < BLOCK; v++) begin
            blk[v] = rand_vec();
        end
        for (int v = 0; v < BLOCK; v++) begin
            drive_vec(1'b1, blk[v]);
        end
        finish_test(`FFT_DEPTH);
        start_test("valid_gaps");
        for (int v = 0; v < BLOCK; v++) begin
            if (v % 3 == 1 || v == BLOCK - 1) begin
                drive_vec(1'b0, rand_vec()); // junk on din while idle
            end
            if (v % 5 == 2) begin
                drive_vec(1'b0, rand_vec());
                drive_vec(1'b0, rand_vec());
            end
            drive_vec(1'b1, blk[v]);
        end
        finish_test(`FFT_DEPTH);
    endtask

    task automatic test_random_blocks();
        start_test("random_blocks");
        for (int v = 0; v < 4 * BLOCK; v++) begin
            drive_vec(1'b1, rand_vec());
        end
        finish_test(4 * `FFT_DEPTH);
    endtask

    initial begin
        rst   = 1'b0;
        valid = 1'b0;
        din   = '0;
        foreach (mdl_dly[i]) begin
            mdl_dly[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b1;

        test_reset_state();
        test_single_block();
        test_twiddle_half();
        test_valid_gaps();
        test_random_blocks();

        if (exp_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("%0d expected results never appeared", exp_q.size());
            abort_run();
        end
    end

endmodule

// File: Bender.yml
package:
  name: fft_stage0

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fft_pkg.sv
      - verilog/bfly_ctrl.sv
      - verilog/bfly_addsub.sv
      - verilog/bfly_rotate.sv
      - verilog/fft_stage0.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/fft_stage0_checker.sv
      - verification/tb_fft_stage0.sv

// File: sources.f
+incdir+verilog
verilog/fft_pkg.sv
verilog/bfly_ctrl.sv
verilog/bfly_addsub.sv
verilog/bfly_rotate.sv
verilog/fft_stage0.sv
verification/fft_stage0_checker.sv
verification/tb_fft_stage0.sv
